// File: soc_pkg.sv
// ========================================
// soc_pkg: peripheral address map, register
// offsets and bus widths of the device slave
// ========================================
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // top address nibble of the device region
    localparam logic [3:0] DEV_REGION = 4'h2;

    // 4 KB slots, address bits 15:12
    typedef enum logic [3:0] {
        SLOT_DISPLAY = 4'd1,
        SLOT_USB     = 4'd4,
        SLOT_KBD     = 4'd5,
        SLOT_SD      = 4'd6,
        SLOT_FLASH   = 4'd7
    } periph_slot_e;

    // register offsets inside a slot
    typedef enum logic [11:0] {
        REG_STATUS  = 12'd0,
        REG_CODE    = 12'd4,
        REG_BTN     = 12'd8,
        REG_MOUSE_X = 12'd12,
        REG_MOUSE_Y = 12'd16
    } reg_off_e;

    // same offsets under their names in the USB and SPI slots
    localparam reg_off_e REG_PINS = REG_STATUS;
    localparam reg_off_e REG_MSW  = REG_CODE;
    localparam reg_off_e REG_LSW  = REG_BTN;

    localparam int KEY_W = 8;

    // {sclk, csn, mosi} after reset, chip deselected
    localparam logic [2:0] PIN_CSN_RESET = 3'b010;

endpackage

`default_nettype wire

// File: code_fifo.sv
// ========================================
// code_fifo: circular buffer with count,
// full and empty flags
// ========================================
`timescale 1ns/1ns
`default_nettype none

module code_fifo #(
    parameter int DEPTH_LOG2 = 5,
    parameter int WIDTH      = 8
) (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic [WIDTH-1:0] wr_data_i,
    input  wire logic             enq_i,
    output      logic             full_o,
    input  wire logic             deq_i,
    output      logic [WIDTH-1:0] rd_data_o,
    output      logic             empty_o
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_enq;
    logic                  do_deq;

    // overflow and underflow requests are dropped
    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_enq)
            mem[wr_ptr] <= wr_data_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_deq)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_enq && !do_deq)
                count <= count + 1'b1;
            else if (do_deq && !do_enq)
                count <= count - 1'b1;
        end
    end

    assign rd_data_o = mem[rd_ptr];
    assign full_o    = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign empty_o   = (count == '0);

endmodule

`default_nettype wire

// File: kbd_port.sv
// ========================================
// kbd_port: key code intake and pop sequence
// ========================================
`timescale 1ns/1ns
`default_nettype none

module kbd_port import soc_pkg::*; #(
    parameter int KBD_FIFO_DEPTH_LOG2 = 5
) (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic [KEY_W-1:0] kbd_code_i,
    input  wire logic             kbd_strobe_i,
    input  wire logic             pop_i,
    output      logic [KEY_W-1:0] code_o,
    output      logic             avail_o
);

    logic             enq_q;
    logic             deq_q;
    logic [KEY_W-1:0] code_q;
    logic [KEY_W-1:0] head;
    logic             full;
    logic             empty;

    // strobe captured here, enqueued one cycle later
    always_ff @(posedge clk) begin
        if (kbd_strobe_i)
            code_q <= kbd_code_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enq_q  <= 1'b0;
            deq_q  <= 1'b0;
            code_o <= '0;
        end else begin
            enq_q <= kbd_strobe_i && !full;
            deq_q <= pop_i;
            // head is taken on the same edge it leaves the FIFO
            if (deq_q)
                code_o <= head;
        end
    end

    code_fifo #(
        .DEPTH_LOG2(KBD_FIFO_DEPTH_LOG2),
        .WIDTH(KEY_W)
    ) code_fifo_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_data_i (code_q),
        .enq_i     (enq_q),
        .full_o    (full),
        .deq_i     (deq_q),
        .rd_data_o (head),
        .empty_o   (empty)
    );

    assign avail_o = !empty;

endmodule

`default_nettype wire

// File: pin_regs.sv
// ========================================
// pin_regs: display byte and bit-banged
// SD card and flash SPI pins
// ========================================
`timescale 1ns/1ns
`default_nettype none

module pin_regs import soc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       disp_we_i,
    input  wire logic       sd_we_i,
    input  wire logic       flash_we_i,
    input  wire logic [7:0] wr_data_i,
    output      logic [7:0] display_o,
    output      logic       sd_csn_o,
    output      logic       sd_sclk_o,
    output      logic       sd_mosi_o,
    output      logic       flash_csn_o,
    output      logic       flash_sclk_o,
    output      logic       flash_mosi_o
);

    logic [2:0] spi_bits;

    // bit 2 sclk, bit 1 cs (active high on the bus), bit 0 mosi
    assign spi_bits = {wr_data_i[2], ~wr_data_i[1], wr_data_i[0]};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o                               <= 8'd0;
            {sd_sclk_o, sd_csn_o, sd_mosi_o}          <= PIN_CSN_RESET;
            {flash_sclk_o, flash_csn_o, flash_mosi_o} <= PIN_CSN_RESET;
        end else begin
            if (disp_we_i)
                display_o <= wr_data_i;
            if (sd_we_i)
                {sd_sclk_o, sd_csn_o, sd_mosi_o} <= spi_bits;
            if (flash_we_i)
                {flash_sclk_o, flash_csn_o, flash_mosi_o} <= spi_bits;
        end
    end

endmodule

`default_nettype wire

// File: tick_timer.sv
// ========================================
// tick_timer: periodic interrupt with an
// end-of-interrupt handshake
// ========================================
`timescale 1ns/1ns
`default_nettype none

module tick_timer #(
    parameter int TIMER_PERIOD = 12000
) (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic eoi_i,
    output      logic irq_o
);

    localparam int CNT_W = $clog2(TIMER_PERIOD);

    typedef enum logic [1:0] {
        IDLE,
        RAISED,
        IN_HANDLER
    } timer_state_e;

    timer_state_e     state;
    logic [CNT_W-1:0] count;
    logic             tick;

    assign tick = (count == '0);

    // free-running reload counter
    always_ff @(posedge clk) begin
        if (reset_i || tick)
            count <= CNT_W'(TIMER_PERIOD - 1);
        else
            count <= count - 1'b1;
    end

    // handler drops eoi on entry, raises it on exit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // a tick with eoi low is lost
                    if (tick && eoi_i)
                        state <= RAISED;
                end
                RAISED: begin
                    if (!eoi_i)
                        state <= IN_HANDLER;
                end
                IN_HANDLER: begin
                    if (eoi_i)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign irq_o = (state != IDLE);

endmodule

`default_nettype wire

// File: wb_decoder.sv
// ========================================
// wb_decoder: Wishbone classic front end,
// ack, write strobes and read-back mux
// ========================================
`timescale 1ns/1ns
`default_nettype none

module wb_decoder import soc_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,

    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    input  wire logic              wb_we_i,
    input  wire logic [ADDR_W-1:0] wb_adr_i,
    input  wire logic [DATA_W-1:0] wb_dat_i,
    input  wire logic [3:0]        wb_sel_i,
    output      logic [DATA_W-1:0] wb_dat_o,
    output      logic              wb_ack_o,

    output      logic              disp_we_o,
    output      logic              sd_we_o,
    output      logic              flash_we_o,
    output      logic              kbd_pop_o,
    output      logic [7:0]        wr_data_o,

    input  wire logic [7:0]        display_i,
    input  wire logic [KEY_W-1:0]  kbd_code_i,
    input  wire logic              kbd_avail_i,
    input  wire logic [2:0]        mouse_btn_i,
    input  wire logic [15:0]       mouse_x_i,
    input  wire logic [15:0]       mouse_y_i,
    input  wire logic [63:0]       usb_report_i,
    input  wire logic              usb_report_valid_i,
    input  wire logic              sd_miso_i,
    input  wire logic              flash_miso_i
);

    logic         in_region;
    periph_slot_e slot;
    reg_off_e     off;
    logic         access;
    logic         wr_access;

    assign in_region = (wb_adr_i[ADDR_W-1 -: 4] == DEV_REGION);
    assign slot      = periph_slot_e'(wb_adr_i[15:12]);
    assign off       = reg_off_e'(wb_adr_i[11:0]);

    // new request sampled while ack is still low
    assign access    = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_access = access && wb_we_i && in_region;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // strobes fire on the edge that raises ack
    assign disp_we_o  = wr_access && (slot == SLOT_DISPLAY) && (off == REG_PINS);
    assign sd_we_o    = wr_access && (slot == SLOT_SD) && (off == REG_PINS);
    assign flash_we_o = wr_access && (slot == SLOT_FLASH) && (off == REG_PINS);
    // pop only when something is queued
    assign kbd_pop_o  = wr_access && (slot == SLOT_KBD) && (off == REG_STATUS) && kbd_avail_i;

    assign wr_data_o  = wb_dat_i[7:0];

    // unmapped reads give zero
    always_comb begin
        wb_dat_o = '0;
        if (in_region) begin
            case (slot)
                SLOT_DISPLAY: begin
                    if (off == REG_PINS)
                        wb_dat_o = DATA_W'(display_i);
                end
                SLOT_USB: begin
                    case (off)
                        REG_STATUS: wb_dat_o = DATA_W'(usb_report_valid_i);
                        REG_MSW:    wb_dat_o = usb_report_i[63:32];
                        REG_LSW:    wb_dat_o = usb_report_i[31:0];
                        default:    wb_dat_o = '0;
                    endcase
                end
                SLOT_KBD: begin
                    case (off)
                        REG_STATUS:  wb_dat_o = DATA_W'(kbd_avail_i);
                        REG_CODE:    wb_dat_o = DATA_W'(kbd_code_i);
                        REG_BTN:     wb_dat_o = DATA_W'(mouse_btn_i);
                        REG_MOUSE_X: wb_dat_o = DATA_W'(mouse_x_i);
                        REG_MOUSE_Y: wb_dat_o = DATA_W'(mouse_y_i);
                        default:     wb_dat_o = '0;
                    endcase
                end
                SLOT_SD: begin
                    if (off == REG_PINS)
                        wb_dat_o = DATA_W'(sd_miso_i);
                end
                SLOT_FLASH: begin
                    if (off == REG_PINS)
                        wb_dat_o = DATA_W'(flash_miso_i);
                end
                default: wb_dat_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: periph_soc.sv
// ========================================
// periph_soc: Wishbone peripheral slave with
// display, keyboard, mouse, USB, SPI, timer
// ========================================
`timescale 1ns/1ns
`default_nettype none

module periph_soc import soc_pkg::*; #(
    parameter int KBD_FIFO_DEPTH_LOG2 = 5,
    parameter int TIMER_PERIOD        = 12000
) (
    input  wire logic              clk,
    input  wire logic              reset_i,

    // Wishbone classic slave
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    input  wire logic              wb_we_i,
    input  wire logic [ADDR_W-1:0] wb_adr_i,
    input  wire logic [DATA_W-1:0] wb_dat_i,
    input  wire logic [3:0]        wb_sel_i,
    output      logic [DATA_W-1:0] wb_dat_o,
    output      logic              wb_ack_o,

    // PS/2 keyboard and mouse
    input  wire logic [KEY_W-1:0]  kbd_code_i,
    input  wire logic              kbd_strobe_i,
    input  wire logic [2:0]        mouse_btn_i,
    input  wire logic [15:0]       mouse_x_i,
    input  wire logic [15:0]       mouse_y_i,

    // USB report
    input  wire logic [63:0]       usb_report_i,
    input  wire logic              usb_report_valid_i,

    // SD card and flash SPI pins
    output      logic              sd_csn_o,
    output      logic              sd_sclk_o,
    output      logic              sd_mosi_o,
    input  wire logic              sd_miso_i,
    output      logic              flash_csn_o,
    output      logic              flash_sclk_o,
    output      logic              flash_mosi_o,
    input  wire logic              flash_miso_i,

    output      logic [7:0]        display_o,

    // timer interrupt
    output      logic              irq_o,
    input  wire logic              eoi_i
);

    logic             disp_we;
    logic             sd_we;
    logic             flash_we;
    logic             kbd_pop;
    logic [7:0]       wr_data;
    logic [KEY_W-1:0] kbd_code;
    logic             kbd_avail;

    wb_decoder wb_decoder_i (
        .clk                (clk),
        .reset_i            (reset_i),
        .wb_cyc_i           (wb_cyc_i),
        .wb_stb_i           (wb_stb_i),
        .wb_we_i            (wb_we_i),
        .wb_adr_i           (wb_adr_i),
        .wb_dat_i           (wb_dat_i),
        .wb_sel_i           (wb_sel_i),
        .wb_dat_o           (wb_dat_o),
        .wb_ack_o           (wb_ack_o),
        .disp_we_o          (disp_we),
        .sd_we_o            (sd_we),
        .flash_we_o         (flash_we),
        .kbd_pop_o          (kbd_pop),
        .wr_data_o          (wr_data),
        .display_i          (display_o),
        .kbd_code_i         (kbd_code),
        .kbd_avail_i        (kbd_avail),
        .mouse_btn_i        (mouse_btn_i),
        .mouse_x_i          (mouse_x_i),
        .mouse_y_i          (mouse_y_i),
        .usb_report_i       (usb_report_i),
        .usb_report_valid_i (usb_report_valid_i),
        .sd_miso_i          (sd_miso_i),
        .flash_miso_i       (flash_miso_i)
    );

    kbd_port #(
        .KBD_FIFO_DEPTH_LOG2(KBD_FIFO_DEPTH_LOG2)
    ) kbd_port_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .kbd_code_i   (kbd_code_i),
        .kbd_strobe_i (kbd_strobe_i),
        .pop_i        (kbd_pop),
        .code_o       (kbd_code),
        .avail_o      (kbd_avail)
    );

    pin_regs pin_regs_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .disp_we_i    (disp_we),
        .sd_we_i      (sd_we),
        .flash_we_i   (flash_we),
        .wr_data_i    (wr_data),
        .display_o    (display_o),
        .sd_csn_o     (sd_csn_o),
        .sd_sclk_o    (sd_sclk_o),
        .sd_mosi_o    (sd_mosi_o),
        .flash_csn_o  (flash_csn_o),
        .flash_sclk_o (flash_sclk_o),
        .flash_mosi_o (flash_mosi_o)
    );

    tick_timer #(
        .TIMER_PERIOD(TIMER_PERIOD)
    ) tick_timer_i (
        .clk     (clk),
        .reset_i (reset_i),
        .eoi_i   (eoi_i),
        .irq_o   (irq_o)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// ========================================
// tb_clock_gen: testbench clock and reset
// ========================================
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 3
) (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // reset drops just after the last reset edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: periph_soc_props.sv
// ========================================
// periph_soc_props: bus handshake and timer
// properties, bound into the slave
// ========================================
`timescale 1ns/1ns
`default_nettype none

module periph_soc_props (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic wb_cyc_i,
    input wire logic wb_stb_i,
    input wire logic wb_ack_o,
    input wire logic irq_o
);

    int unsigned violations = 0;

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)
    else begin
        violations++;
        $error("ack stayed high for two cycles");
    end

    // ack answers a request seen on the previous edge
    ack_after_request: assert property (@(posedge clk) disable iff (reset_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else begin
        violations++;
        $error("ack without cyc and stb");
    end

    irq_low_in_reset: assert property (@(posedge clk)
        reset_i |=> !irq_o)
    else begin
        violations++;
        $error("irq high during reset");
    end

endmodule

bind periph_soc periph_soc_props periph_soc_props_i (
    .clk      (clk),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o)
);

`default_nettype wire

// File: tb_periph_soc.sv
// ========================================
// tb_periph_soc: golden-file driven bus
// master and checker for the slave
// ========================================
`timescale 1ns/1ns
`default_nettype none

module tb_periph_soc;

    localparam int TIMER_PERIOD = 40;
    localparam int DRIVE_DLY    = 1;
    localparam int BUS_TIMEOUT  = 16;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic [7:0]  kbd_code;
    logic        kbd_strobe;
    logic [2:0]  mouse_btn;
    logic [15:0] mouse_x;
    logic [15:0] mouse_y;
    logic [63:0] usb_report;
    logic        usb_valid;
    logic        sd_csn;
    logic        sd_sclk;
    logic        sd_mosi;
    logic        sd_miso;
    logic        flash_csn;
    logic        flash_sclk;
    logic        flash_mosi;
    logic        flash_miso;
    logic [7:0]  display;
    logic        irq;
    logic        eoi;

    string       ops[$];
    logic [31:0] args[$];
    string       vals[$];
    bit          loaded = 1'b0;
    int          cycle = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          errors = 0;

    tb_clock_gen clock_gen_i (
        .clk     (clk),
        .reset_o (reset)
    );

    periph_soc #(
        .TIMER_PERIOD(TIMER_PERIOD)
    ) periph_soc_i (
        .clk(clk), .reset_i(reset),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_sel_i(wb_sel),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack),
        .kbd_code_i(kbd_code), .kbd_strobe_i(kbd_strobe),
        .mouse_btn_i(mouse_btn), .mouse_x_i(mouse_x), .mouse_y_i(mouse_y),
        .usb_report_i(usb_report), .usb_report_valid_i(usb_valid),
        .sd_csn_o(sd_csn), .sd_sclk_o(sd_sclk), .sd_mosi_o(sd_mosi), .sd_miso_i(sd_miso),
        .flash_csn_o(flash_csn), .flash_sclk_o(flash_sclk),
        .flash_mosi_o(flash_mosi), .flash_miso_i(flash_miso),
        .display_o(display), .irq_o(irq), .eoi_i(eoi)
    );

    // edges since reset release, edge 1 is the first one with reset low
    always @(posedge clk) begin
        if (!reset)
            cycle <= cycle + 1;
    end

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        string       op;
        string       vstr;
        logic [31:0] arg;
        fd = $fopen("periph_soc_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file periph_soc_golden.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %h %s", op, arg, vstr);
                if (n == 3) begin
                    ops.push_back(op);
                    args.push_back(arg);
                    vals.push_back(vstr);
                end
            end
        end
        $fclose(fd);
    endtask

    // field layout of the USB and mouse windows
    function automatic logic [31:0] driven_value(input logic [31:0] adr);
        case (adr)
            32'h2000_4000: return {31'd0, usb_valid};
            32'h2000_4004: return usb_report[63:32];
            32'h2000_4008: return usb_report[31:0];
            32'h2000_5008: return {29'd0, mouse_btn};
            32'h2000_500c: return {16'd0, mouse_x};
            32'h2000_5010: return {16'd0, mouse_y};
            default:       return 32'd0;
        endcase
    endfunction

    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat,
                              output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = wdat;
        wb_sel = 4'hf;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end while (!wb_ack && waited < BUS_TIMEOUT);
        rdat = wb_dat_o;
        if (!wb_ack) begin
            $display("no ack from address %h within %0d cycles", adr, BUS_TIMEOUT);
            ok = 1'b0;
        end else if (waited != 1) begin
            $display("FAIL %0t: ack from %h after %0d cycles, expected 1", $time, adr, waited);
            ok = 1'b0;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // one idle cycle between accesses
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic strobe_key(input logic [7:0] code);
        kbd_code   = code;
        kbd_strobe = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        kbd_strobe = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // selectors 00/06/07 check outputs, 16/17/1e drive inputs
    task automatic pin_step(input logic [7:0] sel, input logic [31:0] val, inout logic ok);
        case (sel)
            8'h00: if (display !== val[7:0]) begin
                $display("FAIL %0t: display %h, expected %h", $time, display, val[7:0]);
                ok = 1'b0;
            end
            8'h06: if ({sd_sclk, sd_csn, sd_mosi} !== val[2:0]) begin
                $display("FAIL %0t: sd pins %b, expected %b", $time,
                         {sd_sclk, sd_csn, sd_mosi}, val[2:0]);
                ok = 1'b0;
            end
            8'h07: if ({flash_sclk, flash_csn, flash_mosi} !== val[2:0]) begin
                $display("FAIL %0t: flash pins %b, expected %b", $time,
                         {flash_sclk, flash_csn, flash_mosi}, val[2:0]);
                ok = 1'b0;
            end
            8'h16: sd_miso = val[0];
            8'h17: flash_miso = val[0];
            8'h1e: eoi = val[0];
            default: begin
                $display("unknown pin selector %h in the golden file", sel);
                ok = 1'b0;
            end
        endcase
    endtask

    task automatic run_line(input int idx);
        string       op;
        logic [31:0] arg;
        logic [31:0] val;
        logic [31:0] rdat;
        logic        ok;
        op  = ops[idx];
        arg = args[idx];
        val = '0;
        ok  = 1'b1;
        if (vals[idx] == "rnd")
            val = driven_value(arg);
        else
            void'($sscanf(vals[idx], "%h", val));
        if (op == "WR") begin
            bus_access(1'b1, arg, val, rdat, ok);
        end else if (op == "RD") begin
            bus_access(1'b0, arg, 32'd0, rdat, ok);
            if (ok && rdat !== val) begin
                $display("FAIL %0t: read %h returned %h, expected %h", $time, arg, rdat, val);
                ok = 1'b0;
            end
        end else if (op == "KEY") begin
            strobe_key(arg[7:0]);
        end else if (op == "PIN") begin
            pin_step(arg[7:0], val, ok);
        end else if (op == "EOI") begin
            if (cycle > int'(arg)) begin
                $display("timer step for cycle %0d started late, at cycle %0d", arg, cycle);
                ok = 1'b0;
            end
            while (cycle < int'(arg)) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
            if (irq !== val[0]) begin
                $display("FAIL %0t: irq %b at cycle %0d, expected %b", $time, irq, cycle, val[0]);
                ok = 1'b0;
            end
        end else begin
            $display("unknown operation %s on golden line %0d", op, idx + 1);
            ok = 1'b0;
        end
        if (ok)
            n_pass++;
        else
            n_fail++;
        $display("test %0d %s %h %s", idx + 1, op, arg, ok ? "passed" : "failed");
    endtask

    initial begin
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat     = '0;
        wb_sel     = '0;
        kbd_code   = '0;
        kbd_strobe = 1'b0;
        sd_miso    = 1'b0;
        flash_miso = 1'b0;
        eoi        = 1'b1;
        void'($urandom(53259));
        mouse_btn  = 3'($urandom);
        mouse_x    = 16'($urandom);
        mouse_y    = 16'($urandom);
        usb_report = {$urandom, $urandom};
        usb_valid  = 1'($urandom);
        load_golden();
        loaded = 1'b1;
        @(negedge reset);
        @(posedge clk);
        #DRIVE_DLY;
        for (int i = 0; i < ops.size(); i++)
            run_line(i);
        errors += int'(periph_soc_i.periph_soc_props_i.violations);
        $display("tests: %0d passed, %0d failed, %0d other errors", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // limit scales with the length of the golden file
    initial begin
        wait (loaded);
        repeat (ops.size() * 20 + 4 * TIMER_PERIOD) @(posedge clk);
        $display("watchdog expired before the golden file was done");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: periph_soc_golden.txt
# op  addr/code/selector  value/expected (hex), rnd = value the testbench drove
# PIN 00/06/07 check display, sd, flash {sclk,csn,mosi}; 16/17/1e drive sd miso, flash miso, eoi
# EOI cycle irq: wait for that edge after reset release, then check irq
PIN 00 00
PIN 06 2
PIN 07 2
EOI 01 0
RD 20001000 00000000
EOI 27 0
EOI 28 1
EOI 2c 1
PIN 1e 0
EOI 30 1
PIN 1e 1
EOI 31 0
PIN 1e 0
EOI 50 0
EOI 51 0
PIN 1e 1
WR 20001000 a5
PIN 00 a5
RD 20001000 000000a5
WR 20006000 5
PIN 06 7
PIN 07 2
WR 20007000 6
PIN 07 4
PIN 16 1
RD 20006000 1
PIN 17 1
RD 20007000 1
PIN 16 0
RD 20006000 0
KEY 1c 0
KEY 32 0
KEY f0 0
RD 20005000 1
WR 20005000 0
RD 20005004 1c
WR 20005000 0
RD 20005004 32
WR 20005000 0
RD 20005004 f0
RD 20005000 0
WR 20005000 0
RD 20005004 f0
RD 20004000 rnd
RD 20004004 rnd
RD 20004008 rnd
RD 20005008 rnd
RD 2000500c rnd
RD 20005010 rnd
RD 20002000 0
RD 30001000 0
RD 20001004 0
WR 30001000 ff
WR 20003000 ff
WR 10006000 2
PIN 00 a5
PIN 06 7

// File: flist.f
soc_pkg.sv
code_fifo.sv
kbd_port.sv
pin_regs.sv
tick_timer.sv
wb_decoder.sv
periph_soc.sv
tb_clock_gen.sv
periph_soc_props.sv
tb_periph_soc.sv

// File: Makefile
all: run

build:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_periph_soc

run: build
	./obj_dir/Vtb_periph_soc | tee sim.log
	grep -q "^No errors$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module tb_periph_soc

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
